/* hw/dispatch_cfg_pkg.sv */
`default_nettype none

package dispatch_cfg_pkg;

   // ==========================================================================
   // Datapath
   // ==========================================================================

   localparam int XLEN        = 32;   // Operand and result width

   // Architectural register file
   localparam int ARCH_REGS   = 32;
   localparam int ARCH_ADDR_W = 5;

   // ==========================================================================
   // Reorder buffer and station
   // ==========================================================================

   // Tags are plain ROB indices
   localparam int ROB_DEPTH   = 32;
   localparam int ROB_IDX_W   = 5;

   // Renamed operand address
   localparam int PHYS_ADDR_W = 6;    // MSB set selects the ROB

   localparam int RS_DEPTH    = 4;    // Entries in the single station
   localparam int RS_IDX_W    = 2;

endpackage

`default_nettype wire

/* hw/dispatch_types_pkg.sv */
`default_nettype none

package dispatch_types_pkg;

   import dispatch_cfg_pkg::*;

   // ==========================================================================
   // Encodings
   // ==========================================================================

   typedef enum logic [2:0] {
      ALU_ADD = 3'd0,
      ALU_SUB = 3'd1,
      ALU_AND = 3'd2,
      ALU_OR  = 3'd3,
      ALU_XOR = 3'd4
   } alu_op_e;

   typedef enum logic [1:0] {
      ROB_FREE    = 2'd0,
      ROB_WAITING = 2'd1,   // Allocated, result outstanding
      ROB_DONE    = 2'd2    // Result seen on the CDB
   } rob_state_e;

   // ==========================================================================
   // Bundles between blocks
   // ==========================================================================

   typedef struct packed {
      logic                   in_rob;   // Index names a ROB entry
      logic [PHYS_ADDR_W-2:0] idx;
   } phys_addr_t;

   // Issue stage request
   typedef struct packed {
      alu_op_e                op;
      phys_addr_t             src_a;
      phys_addr_t             src_b;
      logic [XLEN-1:0]        imm;
      logic                   use_imm;  // Immediate replaces operand B
      logic [ARCH_ADDR_W-1:0] rd;
   } dispatch_req_t;

   typedef struct packed {
      logic [XLEN-1:0] data;
      logic            done;
   } rob_read_t;

   // To the functional unit
   typedef struct packed {
      alu_op_e              op;
      logic [XLEN-1:0]      operand_a;
      logic [XLEN-1:0]      operand_b;
      logic [ROB_IDX_W-1:0] rob_idx;    // Tag returned on the CDB
   } exec_req_t;

   typedef struct packed {
      logic                 valid;
      logic [ROB_IDX_W-1:0] rob_idx;
      logic [XLEN-1:0]      data;
   } cdb_t;

   typedef struct packed {
      logic                   valid;
      logic [ARCH_ADDR_W-1:0] rd;
      logic [XLEN-1:0]        data;
      logic [ROB_IDX_W-1:0]   rob_idx;
   } commit_t;

endpackage

`default_nettype wire

/* hw/arch_reg_file.sv */
`default_nettype none

module arch_reg_file (
   input  wire                                     clk_i,
   input  wire                                     rst_n_i,
   input  wire [dispatch_cfg_pkg::ARCH_ADDR_W-1:0] rd_addr_a_i,
   input  wire [dispatch_cfg_pkg::ARCH_ADDR_W-1:0] rd_addr_b_i,
   output logic [dispatch_cfg_pkg::XLEN-1:0]       rd_data_a_o,
   output logic [dispatch_cfg_pkg::XLEN-1:0]       rd_data_b_o,
   input  wire dispatch_types_pkg::commit_t        commit_i
);

   import dispatch_cfg_pkg::*;
   import dispatch_types_pkg::*;

   logic [XLEN-1:0] regs_q [ARCH_REGS];   // Committed state

   // ==========================================================================
   // Commit write port
   // ==========================================================================

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         for (int i = 0; i < ARCH_REGS; i++) begin
            regs_q[i] <= '0;
         end
      end else if (commit_i.valid && (commit_i.rd != '0)) begin
         regs_q[commit_i.rd] <= commit_i.data;   // Visible next cycle
      end
   end

   // Combinational reads
   // x0 forced to zero
   assign rd_data_a_o = (rd_addr_a_i == '0) ? '0 : regs_q[rd_addr_a_i];
   assign rd_data_b_o = (rd_addr_b_i == '0) ? '0 : regs_q[rd_addr_b_i];

endmodule

`default_nettype wire

/* hw/reorder_buffer.sv */
`default_nettype none

module reorder_buffer (
   input  wire                                     clk_i,
   input  wire                                     rst_n_i,
   // Allocation from the station
   input  wire                                     alloc_i,
   input  wire [dispatch_cfg_pkg::ARCH_ADDR_W-1:0] alloc_rd_i,
   output logic [dispatch_cfg_pkg::ROB_IDX_W-1:0]  tail_idx_o,
   output logic                                    full_o,
   // Operand read ports
   input  wire [dispatch_cfg_pkg::ROB_IDX_W-1:0]   read_idx_a_i,
   input  wire [dispatch_cfg_pkg::ROB_IDX_W-1:0]   read_idx_b_i,
   output dispatch_types_pkg::rob_read_t           read_a_o,
   output dispatch_types_pkg::rob_read_t           read_b_o,
   // Results and retirement
   input  wire dispatch_types_pkg::cdb_t           cdb_i,
   output dispatch_types_pkg::commit_t             commit_o
);

   import dispatch_cfg_pkg::*;
   import dispatch_types_pkg::*;

   rob_state_e             state_q [ROB_DEPTH];
   logic [ARCH_ADDR_W-1:0] rd_q    [ROB_DEPTH];   // Destination per entry
   logic [XLEN-1:0]        data_q  [ROB_DEPTH];   // Result per entry
   logic [ROB_IDX_W-1:0]   head_q;                // Oldest uncommitted
   logic [ROB_IDX_W-1:0]   tail_q;                // Next to allocate
   logic [ROB_IDX_W:0]     count_q;
   logic                   cdb_hit;
   logic                   commit_fire;

   assign tail_idx_o = tail_q;
   assign full_o     = (count_q == (ROB_IDX_W+1)'(ROB_DEPTH));

   // Only a waiting entry takes a result
   assign cdb_hit     = cdb_i.valid && (state_q[cdb_i.rob_idx] == ROB_WAITING);
   assign commit_fire = (state_q[head_q] == ROB_DONE);

   // ==========================================================================
   // Operand reads
   // ==========================================================================

   // Freed entries still report done with their old data
   always_comb begin
      read_a_o.data = data_q[read_idx_a_i];
      read_a_o.done = (state_q[read_idx_a_i] != ROB_WAITING);
      read_b_o.data = data_q[read_idx_b_i];
      read_b_o.done = (state_q[read_idx_b_i] != ROB_WAITING);
   end

   // In-order retirement
   always_comb begin
      commit_o.valid   = commit_fire;
      commit_o.rd      = rd_q[head_q];
      commit_o.data    = data_q[head_q];
      commit_o.rob_idx = head_q;
   end

   // ==========================================================================
   // Entry state and pointers
   // ==========================================================================

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         head_q  <= '0;
         tail_q  <= '0;
         count_q <= '0;
         for (int i = 0; i < ROB_DEPTH; i++) begin
            state_q[i] <= ROB_FREE;
         end
      end else begin
         if (commit_fire) begin
            state_q[head_q] <= ROB_FREE;
            head_q          <= head_q + 1'b1;   // Wraps at ROB_DEPTH
         end
         if (cdb_hit) begin
            state_q[cdb_i.rob_idx] <= ROB_DONE;
         end
         // Tail never meets a busy entry since the station checks full
         if (alloc_i) begin
            state_q[tail_q] <= ROB_WAITING;
            tail_q          <= tail_q + 1'b1;
         end
         count_q <= count_q + (ROB_IDX_W+1)'(alloc_i) - (ROB_IDX_W+1)'(commit_fire);
      end
   end

   // Payload
   always_ff @(posedge clk_i) begin
      if (alloc_i) begin
         rd_q[tail_q] <= alloc_rd_i;
      end
      if (cdb_hit) begin
         data_q[cdb_i.rob_idx] <= cdb_i.data;
      end
   end

endmodule

`default_nettype wire

/* hw/reservation_station.sv */
`default_nettype none

module reservation_station (
   input  wire                                    clk_i,
   input  wire                                    rst_n_i,
   // Dispatch handshake from the issue stage
   input  wire                                    dispatch_valid_i,
   input  wire dispatch_types_pkg::dispatch_req_t dispatch_req_i,
   output logic                                   dispatch_ready_o,
   // ROB allocation
   input  wire                                    rob_full_i,
   input  wire [dispatch_cfg_pkg::ROB_IDX_W-1:0]  tail_idx_i,
   output logic                                   alloc_o,
   // Operand sources
   input  wire [dispatch_cfg_pkg::XLEN-1:0]       rf_data_a_i,
   input  wire [dispatch_cfg_pkg::XLEN-1:0]       rf_data_b_i,
   input  wire dispatch_types_pkg::rob_read_t     rob_a_i,
   input  wire dispatch_types_pkg::rob_read_t     rob_b_i,
   input  wire dispatch_types_pkg::cdb_t          cdb_i,
   // Issue handshake to the functional unit
   output logic                                   exec_valid_o,
   output dispatch_types_pkg::exec_req_t          exec_req_o,
   input  wire                                    exec_ready_i
);

   import dispatch_cfg_pkg::*;
   import dispatch_types_pkg::*;

   // Operand slot, value valid when rdy
   typedef struct packed {
      logic                 rdy;
      logic [ROB_IDX_W-1:0] tag;
      logic [XLEN-1:0]      val;
   } opnd_t;

   typedef struct packed {
      alu_op_e              op;
      opnd_t                a;
      opnd_t                b;
      logic [ROB_IDX_W-1:0] rob_idx;   // Own tag
   } rs_entry_t;

   logic [RS_DEPTH-1:0] valid_q;
   rs_entry_t           ent_q [RS_DEPTH];
   rs_entry_t           new_ent;
   logic                up_q;          // Set once out of reset
   logic                lock_q;        // Offer stalled last cycle
   logic [RS_IDX_W-1:0] lock_idx_q;
   logic                free_found;
   logic [RS_IDX_W-1:0] free_idx;
   logic                sel_found;
   logic [RS_IDX_W-1:0] sel_idx;
   logic                issue_fire;

   // ==========================================================================
   // Operand combining
   // ==========================================================================

   // Register file, done ROB entry, CDB bypass, else wait on the tag
   function automatic opnd_t resolve(input phys_addr_t src, input logic [XLEN-1:0] rf_data,
                                     input rob_read_t rob, input cdb_t cdb);
      opnd_t o;
      o.tag = src.idx;
      o.rdy = 1'b1;
      if (!src.in_rob) begin
         o.val = rf_data;
      end else if (rob.done) begin
         o.val = rob.data;
      end else if (cdb.valid && (cdb.rob_idx == src.idx)) begin
         o.val = cdb.data;
      end else begin
         o.rdy = 1'b0;
         o.val = '0;
      end
      return o;
   endfunction

   // CDB snoop for a stored operand
   function automatic opnd_t wake(input opnd_t o, input cdb_t cdb);
      opnd_t w;
      w = o;
      if (!o.rdy && cdb.valid && (cdb.rob_idx == o.tag)) begin
         w.rdy = 1'b1;
         w.val = cdb.data;
      end
      return w;
   endfunction

   always_comb begin
      new_ent.op      = dispatch_req_i.op;
      new_ent.a       = resolve(dispatch_req_i.src_a, rf_data_a_i, rob_a_i, cdb_i);
      new_ent.b       = resolve(dispatch_req_i.src_b, rf_data_b_i, rob_b_i, cdb_i);
      new_ent.rob_idx = tail_idx_i;
      if (dispatch_req_i.use_imm) begin
         new_ent.b.rdy = 1'b1;
         new_ent.b.val = dispatch_req_i.imm;
      end
   end

   // ==========================================================================
   // Dispatch side
   // ==========================================================================

   // Lowest free slot
   always_comb begin
      free_found = 1'b0;
      free_idx   = '0;
      for (int i = RS_DEPTH-1; i >= 0; i--) begin
         if (!valid_q[i]) begin
            free_found = 1'b1;
            free_idx   = RS_IDX_W'(i);
         end
      end
   end

   assign dispatch_ready_o = up_q && free_found && !rob_full_i;   // Independent of valid
   assign alloc_o          = dispatch_valid_i && dispatch_ready_o;

   // ==========================================================================
   // Issue side
   // ==========================================================================

   // Lowest ready entry unless an offer is pending
   always_comb begin
      sel_found = 1'b0;
      sel_idx   = '0;
      for (int i = RS_DEPTH-1; i >= 0; i--) begin
         if (valid_q[i] && ent_q[i].a.rdy && ent_q[i].b.rdy) begin
            sel_found = 1'b1;
            sel_idx   = RS_IDX_W'(i);
         end
      end
      if (lock_q) begin
         sel_found = 1'b1;          // Held entry stays ready
         sel_idx   = lock_idx_q;
      end
   end

   assign exec_valid_o = sel_found;
   assign issue_fire   = exec_valid_o && exec_ready_i;

   always_comb begin
      exec_req_o.op        = ent_q[sel_idx].op;
      exec_req_o.operand_a = ent_q[sel_idx].a.val;
      exec_req_o.operand_b = ent_q[sel_idx].b.val;
      exec_req_o.rob_idx   = ent_q[sel_idx].rob_idx;
   end

   always_ff @(posedge clk_i or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q    <= '0;
         up_q       <= 1'b0;
         lock_q     <= 1'b0;
         lock_idx_q <= '0;
      end else begin
         up_q       <= 1'b1;
         lock_q     <= exec_valid_o && !exec_ready_i;
         lock_idx_q <= sel_idx;
         if (issue_fire) begin
            valid_q[sel_idx] <= 1'b0;
         end
         if (alloc_o) begin
            valid_q[free_idx] <= 1'b1;    // Never the slot being issued
         end
      end
   end

   // Wakeup then fill
   always_ff @(posedge clk_i) begin
      for (int i = 0; i < RS_DEPTH; i++) begin
         ent_q[i].a <= wake(ent_q[i].a, cdb_i);
         ent_q[i].b <= wake(ent_q[i].b, cdb_i);
      end
      if (alloc_o) begin
         ent_q[free_idx] <= new_ent;
      end
   end

endmodule

`default_nettype wire

/* hw/dispatch_stage.sv */
`default_nettype none

module dispatch_stage (
   input  wire                                    clk_i,
   input  wire                                    rst_n_i,
   // Issue stage
   input  wire                                    dispatch_valid_i,
   input  wire dispatch_types_pkg::dispatch_req_t dispatch_req_i,
   output logic                                   dispatch_ready_o,
   // Functional unit
   output logic                                   exec_valid_o,
   output dispatch_types_pkg::exec_req_t          exec_req_o,
   input  wire                                    exec_ready_i,
   input  wire dispatch_types_pkg::cdb_t          cdb_i,
   // Retirement
   output dispatch_types_pkg::commit_t            commit_o
);

   import dispatch_cfg_pkg::*;
   import dispatch_types_pkg::*;

   logic [XLEN-1:0]      rf_data_a;
   logic [XLEN-1:0]      rf_data_b;
   rob_read_t            rob_read_a;
   rob_read_t            rob_read_b;
   logic [ROB_IDX_W-1:0] tail_idx;
   logic                 rob_full;
   logic                 alloc;

   // ==========================================================================
   // Operand sources
   // ==========================================================================

   // Both read with the same low index bits
   arch_reg_file u_arch_reg_file (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rd_addr_a_i (dispatch_req_i.src_a.idx),
      .rd_addr_b_i (dispatch_req_i.src_b.idx),
      .rd_data_a_o (rf_data_a),
      .rd_data_b_o (rf_data_b),
      .commit_i    (commit_o)       // Written on every commit
   );

   reorder_buffer u_reorder_buffer (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .alloc_i      (alloc),
      .alloc_rd_i   (dispatch_req_i.rd),
      .tail_idx_o   (tail_idx),
      .full_o       (rob_full),
      .read_idx_a_i (dispatch_req_i.src_a.idx),
      .read_idx_b_i (dispatch_req_i.src_b.idx),
      .read_a_o     (rob_read_a),
      .read_b_o     (rob_read_b),
      .cdb_i        (cdb_i),
      .commit_o     (commit_o)
   );

   // ==========================================================================
   // Scheduling
   // ==========================================================================

   reservation_station u_reservation_station (
      .clk_i            (clk_i),
      .rst_n_i          (rst_n_i),
      .dispatch_valid_i (dispatch_valid_i),
      .dispatch_req_i   (dispatch_req_i),
      .dispatch_ready_o (dispatch_ready_o),
      .rob_full_i       (rob_full),
      .tail_idx_i       (tail_idx),
      .alloc_o          (alloc),
      .rf_data_a_i      (rf_data_a),
      .rf_data_b_i      (rf_data_b),
      .rob_a_i          (rob_read_a),
      .rob_b_i          (rob_read_b),
      .cdb_i            (cdb_i),      // Same pulse as the ROB sees
      .exec_valid_o     (exec_valid_o),
      .exec_req_o       (exec_req_o),
      .exec_ready_i     (exec_ready_i)
   );

endmodule

`default_nettype wire

/* test/dispatch_stage_sva.sv */
`default_nettype none

module dispatch_stage_sva (
   input wire                                    clk_i,
   input wire                                    rst_n_i,
   input wire                                    dispatch_valid_i,
   input wire dispatch_types_pkg::dispatch_req_t dispatch_req_i,
   input wire                                    dispatch_ready_o,
   input wire                                    exec_valid_o,
   input wire dispatch_types_pkg::exec_req_t     exec_req_o,
   input wire                                    exec_ready_i,
   input wire dispatch_types_pkg::commit_t       commit_o
);

   // ==========================================================================
   // Handshake stability
   // ==========================================================================

   // Issue stage holds a stalled request
   dispatch_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      dispatch_valid_i && !dispatch_ready_o |=> dispatch_valid_i && $stable(dispatch_req_i))
      else $error("dispatch request dropped or changed while stalled");

   // Offered entry stays put under back-pressure
   exec_hold_a : assert property (@(posedge clk_i) disable iff (!rst_n_i)
      exec_valid_o && !exec_ready_i |=> exec_valid_o && $stable(exec_req_o))
      else $error("exec request dropped or changed under back-pressure");

   // Quiet outputs in reset
   reset_quiet_a : assert property (@(posedge clk_i)
      !rst_n_i |-> !exec_valid_o && !commit_o.valid)
      else $error("exec or commit valid during reset");

endmodule

bind dispatch_stage dispatch_stage_sva u_sva (.*);

`default_nettype wire

/* test/tb_dispatch_stage.sv */
`default_nettype none

module tb_dispatch_stage;

   import dispatch_cfg_pkg::*;
   import dispatch_types_pkg::*;

   logic          clk;
   logic          rst_n;
   logic          dispatch_valid;
   logic          dispatch_ready;
   logic          exec_valid;
   logic          exec_ready;
   dispatch_req_t dispatch_req;
   exec_req_t     exec_req;
   cdb_t          cdb;
   commit_t       commit;

   logic [31:0] lfsr_q = 32'h04986564;
   int          cycle;
   logic [31:0] model_rf [32];                // Committed register values
   bit          map_valid [32];               // Rename map from arch reg to ROB index
   logic [4:0]  map_idx [32];
   alu_op_e     exp_op [32];                  // Per ROB index
   logic [31:0] exp_a [32];
   logic [31:0] exp_b [32];
   logic [31:0] res [32];
   logic [4:0]  rd_of [32];
   bit          long_of [32];
   int          tail_cnt;
   int          head_cnt;
   int          pend_idx [$];                 // Results waiting for the CDB
   int          pend_due [$];
   bit          rob_full_seen;
   bit          bp_checked;

   dispatch_stage dut (
      .clk_i            (clk),
      .rst_n_i          (rst_n),
      .dispatch_valid_i (dispatch_valid),
      .dispatch_req_i   (dispatch_req),
      .dispatch_ready_o (dispatch_ready),
      .exec_valid_o     (exec_valid),
      .exec_req_o       (exec_req),
      .exec_ready_i     (exec_ready),
      .cdb_i            (cdb),
      .commit_o         (commit)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // ==========================================================================
   // Helpers
   // ==========================================================================

   task automatic stop_run(input string why);
      $display("%s", why);
      $display("STATUS: FAIL");
      $fatal(1);
   endtask

   task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
      assert (got === exp) else
         stop_run($sformatf("[ERROR] %0t %s got %h expected %h", $time, name, got, exp));
   endtask

   // Taps 32 22 2 1
   function automatic logic [31:0] rand_bits(input int n);
      logic [31:0] v;
      logic        fb;
      v = '0;
      for (int i = 0; i < n; i++) begin
         fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
         lfsr_q = {lfsr_q[30:0], fb};
         v      = {v[30:0], fb};
      end
      return v;
   endfunction

   function automatic logic [31:0] alu_model(input alu_op_e op, input logic [31:0] a,
                                             input logic [31:0] b);
      case (op)
         ALU_ADD: return a + b;   // Wraps
         ALU_SUB: return a - b;
         ALU_AND: return a & b;
         ALU_OR:  return a | b;
         ALU_XOR: return a ^ b;
         default: return '0;
      endcase
   endfunction

   // Operand value as the issue stage sees it
   function automatic logic [31:0] src_value(input logic [4:0] r);
      if (r != 5'd0 && map_valid[r]) return res[map_idx[r]];
      return (r == 5'd0) ? 32'd0 : model_rf[r];
   endfunction

   function automatic phys_addr_t src_phys(input logic [4:0] r);
      phys_addr_t p;
      p.in_rob = (r != 5'd0) && map_valid[r];
      p.idx    = p.in_rob ? map_idx[r] : r;
      return p;
   endfunction

   // ==========================================================================
   // Stream engine acting as issue stage and functional unit
   // ==========================================================================

   // kind 0 imm adds, 1 chain, 2 reg reads, 3 back-pressure, 4 random
   // ready_mode 0 always, 1 random, 2 low until hold
   task automatic run_stream(input int n, input int kind, input int ready_mode, input int hold);
      int            t;
      int            sent;
      int            committed;
      int            occ;
      int            d;
      bit            have_req;
      bit            held_valid;
      bit            lng;
      exec_req_t     held_req;
      dispatch_req_t req;
      alu_op_e       op;
      logic [4:0]    ra;
      logic [4:0]    rb;
      logic [4:0]    rd;
      logic [4:0]    last_rd;
      logic [4:0]    idx;
      logic          ui;
      logic [31:0]   imm;
      logic [31:0]   ea;
      logic [31:0]   eb;
      logic [31:0]   r;
      t = 0;
      sent = 0;
      committed = 0;
      have_req = 0;
      held_valid = 0;
      last_rd = '0;
      while (committed < n) begin
         @(negedge clk);
         cycle++;
         t++;
         if (t > 20000) stop_run("timeout: stream did not drain within 20000 cycles");
         // First due result goes on the CDB
         cdb = '0;
         for (int j = 0; j < pend_idx.size(); j++) begin
            if (pend_due[j] <= cycle) begin
               cdb.valid   = 1'b1;
               cdb.rob_idx = 5'(pend_idx[j]);
               cdb.data    = res[pend_idx[j]];
               pend_idx.delete(j);
               pend_due.delete(j);
               break;
            end
         end
         case (ready_mode)
            0:       exec_ready = 1'b1;
            1:       exec_ready = (rand_bits(2) != 32'd0);
            default: exec_ready = (t >= hold);
         endcase
         if (!have_req && sent < n) begin
            op  = ALU_ADD;
            ra  = '0;
            rb  = '0;
            ui  = 1'b1;
            lng = 0;
            imm = rand_bits(32);
            case (kind)
               0: rd = 5'(sent + 1);
               3: rd = 5'(sent + 20);
               1: begin
                  op = (sent % 2 == 1) ? ALU_SUB : ALU_ADD;
                  ra = last_rd;                     // Previous ROB entry
                  if (sent % 3 == 2) begin
                     ui = 1'b0;
                     rb = last_rd;
                     op = ALU_XOR;
                  end
                  rd = 5'(sent % 5 + 1);
               end
               2: begin
                  op = ALU_OR;
                  ui = 1'b0;
                  ra = 5'(sent % 5 + 1);
                  rb = 5'((sent + 1) % 5 + 1);
                  rd = 5'(sent + 10);
               end
               default: begin
                  op = alu_op_e'(3'(rand_bits(3) % 5));
                  ra = 5'(rand_bits(5));
                  rb = 5'(rand_bits(5));
                  ui = rand_bits(1) != 32'd0;
                  rd = 5'(rand_bits(5));
                  if (sent % 40 == 5) begin
                     lng = 1;                        // Stalls the head and nobody reads it
                     rd  = '0;
                  end
               end
            endcase
            last_rd = rd;
            ea = src_value(ra);
            eb = ui ? imm : src_value(rb);
            r  = alu_model(op, ea, eb);
            req.op      = op;
            req.src_a   = src_phys(ra);
            req.src_b   = src_phys(rb);
            req.imm     = imm;
            req.use_imm = ui;
            req.rd      = rd;
            have_req    = 1;
         end
         dispatch_valid = have_req;
         dispatch_req   = req;
         #1;
         occ = tail_cnt - head_cnt;
         if (occ == ROB_DEPTH) begin
            rob_full_seen = 1;
            check_eq("dispatch_ready_o at full ROB", 32'(dispatch_ready), 32'd0);
         end
         if (ready_mode == 2 && t < hold && sent >= RS_DEPTH) begin
            bp_checked = 1;
            check_eq("dispatch_ready_o at full station", 32'(dispatch_ready), 32'd0);
         end
         // Commit happens at the coming edge
         if (commit.valid) begin
            idx = 5'(head_cnt);
            check_eq("commit_o.rob_idx", 32'(commit.rob_idx), 32'(idx));
            check_eq("commit_o.rd", 32'(commit.rd), 32'(rd_of[idx]));
            check_eq("commit_o.data", commit.data, res[idx]);
            if (rd_of[idx] != 5'd0) model_rf[rd_of[idx]] = res[idx];
            if (map_valid[rd_of[idx]] && map_idx[rd_of[idx]] == idx) map_valid[rd_of[idx]] = 0;
            head_cnt++;
            committed++;
         end
         if (have_req && dispatch_ready) begin
            idx          = 5'(tail_cnt);
            exp_op[idx]  = req.op;
            exp_a[idx]   = ea;
            exp_b[idx]   = eb;
            res[idx]     = r;
            rd_of[idx]   = req.rd;
            long_of[idx] = lng;
            if (req.rd != 5'd0) begin
               map_valid[req.rd] = 1;
               map_idx[req.rd]   = idx;
            end
            tail_cnt++;
            sent++;
            have_req = 0;
         end
         if (exec_valid) begin
            if (held_valid) begin
               assert (exec_req == held_req) else
                  stop_run($sformatf("[ERROR] %0t exec_req_o got %h expected %h", $time,
                                     exec_req, held_req));
            end
            if (exec_ready) begin
               idx = exec_req.rob_idx;
               check_eq("exec_req_o.op", 32'(exec_req.op), 32'(exp_op[idx]));
               check_eq("exec_req_o.operand_a", exec_req.operand_a, exp_a[idx]);
               check_eq("exec_req_o.operand_b", exec_req.operand_b, exp_b[idx]);
               d = long_of[idx] ? 100 : int'(rand_bits(3));
               pend_idx.push_back(int'(idx));
               pend_due.push_back(cycle + 1 + d);
               held_valid = 0;
            end else begin
               held_valid = 1;
               held_req   = exec_req;
            end
         end
      end
      dispatch_valid = 1'b0;
      cdb            = '0;
   endtask

   // ==========================================================================
   // Directed tests
   // ==========================================================================

   task automatic test_reset_state();
      @(negedge clk);
      #1;
      check_eq("exec_valid_o", 32'(exec_valid), 32'd0);
      check_eq("commit_o.valid", 32'(commit.valid), 32'd0);
      check_eq("dispatch_ready_o", 32'(dispatch_ready), 32'd1);
      run_stream(4, 0, 0, 0);
   endtask

   task automatic test_dependency_chain();
      run_stream(12, 1, 0, 0);
   endtask

   task automatic test_reg_file_path();
      run_stream(5, 2, 0, 0);
   endtask

   task automatic test_back_pressure();
      run_stream(8, 3, 2, 20);
      assert (bp_checked) else stop_run("station never filled under back-pressure");
   endtask

   task automatic test_random_mix();
      run_stream(200, 4, 1, 0);
      assert (rob_full_seen) else stop_run("reorder buffer never reached full");
   endtask

   initial begin
      rst_n          = 1'b0;
      dispatch_valid = 1'b0;
      dispatch_req   = '0;
      exec_ready     = 1'b0;
      cdb            = '0;
      cycle          = 0;
      tail_cnt       = 0;
      head_cnt       = 0;
      for (int i = 0; i < 32; i++) begin
         model_rf[i]  = '0;
         map_valid[i] = 0;
      end
      repeat (5) @(posedge clk);
      @(negedge clk);
      check_eq("dispatch_ready_o in reset", 32'(dispatch_ready), 32'd0);
      rst_n = 1'b1;
      test_reset_state();
      test_dependency_chain();
      test_reg_file_path();
      test_back_pressure();
      test_random_mix();
      $display("STATUS: PASS");
      $finish;
   end

endmodule

`default_nettype wire

/* all.f */
hw/dispatch_cfg_pkg.sv
hw/dispatch_types_pkg.sv
hw/arch_reg_file.sv
hw/reorder_buffer.sv
hw/reservation_station.sv
hw/dispatch_stage.sv
test/dispatch_stage_sva.sv
test/tb_dispatch_stage.sv

/* Makefile */
LOG := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check $(LOG)"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --timing --assert --top-module tb_dispatch_stage -f all.f
	-./obj_dir/Vtb_dispatch_stage | tee $(LOG)
	@grep -q "STATUS: PASS" $(LOG) || (echo "simulation failed" && exit 1)

clean:
	rm -rf obj_dir $(LOG)
